// File: hdl/core_pkg.sv
package core_pkg;

    // machine word width
    localparam int XLEN = 32;

    // rv32 major opcodes, bits [6:0] of the instruction
    typedef enum logic [6:0] {
        OP_ILLEGAL = 7'b0000000,   // all-zero word, never a valid encoding
        OP_IMM     = 7'b0010011,   // addi
        OP         = 7'b0110011,   // add, sub, xor
        LUI        = 7'b0110111,
        BRANCH     = 7'b1100011,   // bne only
        SYSTEM     = 7'b1110011    // ebreak only
    } opcode_e;

    // alu function select
    typedef enum logic [2:0] {
        ALU_ADD    = 3'd0,
        ALU_SUB    = 3'd1,
        ALU_XOR    = 3'd2,
        ALU_PASS_B = 3'd3,   // lui, operand b straight through
        ALU_NE     = 3'd4    // compare for bne, result is 0 or 1
    } alu_op_e;

    // read channel sequencing in the bus master
    typedef enum logic [1:0] {
        RD_IDLE    = 2'b00,
        RD_AR_WAIT = 2'b01,  // address out, waiting for arready
        RD_R_WAIT  = 2'b11   // address taken, waiting for rvalid
    } rd_state_e;

    // core sequencing, one instruction in flight
    typedef enum logic [1:0] {
        CORE_FETCH = 2'b00,
        CORE_EXEC  = 2'b01,
        CORE_HALT  = 2'b10   // sticky until reset
    } core_state_e;

    // axi response codes
    // only okay is accepted, anything else is a fetch fault
    localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

endpackage

// File: hdl/axi_rd_master.sv
`timescale 1ns/1ns

module axi_rd_master #(
    parameter int AXI_ADDR_WIDTH = 32
) (
    input  logic                      clock,
    input  logic                      reset,

    // strobe side, towards fetch
    input  logic                      rw_valid_i,      // one-cycle request
    input  logic [AXI_ADDR_WIDTH-1:0] rw_addr_i,       // sampled with the request
    output logic                      rw_ready_o,      // one-cycle done
    output logic                      rw_err_o,        // valid with done
    output logic [63:0]               data_read_o,     // valid with done

    // read address channel
    input  logic                      axi_ar_ready_i,
    output logic                      axi_ar_valid_o,
    output logic [AXI_ADDR_WIDTH-1:0] axi_ar_addr_o,

    // read data channel
    output logic                      axi_r_ready_o,
    input  logic                      axi_r_valid_i,
    input  logic [63:0]               axi_r_data_i,
    input  logic [1:0]                axi_r_resp_i
);
    import core_pkg::*;

    rd_state_e                 state_q;
    rd_state_e                 state_d;
    logic [AXI_ADDR_WIDTH-1:0] addr_q;    // address copy, caller may move on
    logic                      ar_hs;
    logic                      r_hs;

    assign ar_hs = axi_ar_valid_o && axi_ar_ready_i;
    assign r_hs  = axi_r_ready_o && axi_r_valid_i;

    // next state
    always_comb begin
        state_d = state_q;
        case (state_q)
            RD_IDLE:    if (rw_valid_i) state_d = RD_AR_WAIT;
            RD_AR_WAIT: if (ar_hs)      state_d = RD_R_WAIT;
            RD_R_WAIT:  if (r_hs)       state_d = RD_IDLE;
            default:                    state_d = RD_IDLE;
        endcase
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state_q    <= RD_IDLE;
            rw_ready_o <= 1'b0;
            rw_err_o   <= 1'b0;
        end else begin
            state_q    <= state_d;
            rw_ready_o <= r_hs;    // done one cycle after the r handshake
            rw_err_o   <= r_hs && (axi_r_resp_i != AXI_RESP_OKAY);
        end
    end

    // payload, no reset
    always_ff @(posedge clock) begin
        if (state_q == RD_IDLE && rw_valid_i) begin
            addr_q <= rw_addr_i;
        end
        if (r_hs) begin
            data_read_o <= axi_r_data_i;
        end
    end

    // outputs straight from state, valid drops the cycle after handshake
    assign axi_ar_valid_o = (state_q == RD_AR_WAIT);
    assign axi_ar_addr_o  = addr_q;
    assign axi_r_ready_o  = (state_q == RD_R_WAIT);

    // address phase must not collapse under a slave stall
    a_ar_hold: assert property (@(posedge clock) disable iff (!reset)
        axi_ar_valid_o && !axi_ar_ready_i |=> axi_ar_valid_o && $stable(axi_ar_addr_o));

    // fetch side waits for done before asking again
    a_req_idle: assert property (@(posedge clock) disable iff (!reset)
        rw_valid_i |-> state_q == RD_IDLE);

endmodule

// File: hdl/fetch_ctrl.sv
`timescale 1ns/1ns

module fetch_ctrl #(
    parameter logic [core_pkg::XLEN-1:0] RESET_PC = '0
) (
    input  logic                      clock,
    input  logic                      reset,
    output logic                      fetch_req_o,      // one-cycle pulse
    output logic [core_pkg::XLEN-1:0] fetch_addr_o,
    input  logic                      fetch_done_i,
    input  logic [63:0]               fetch_data_i,
    input  logic                      fetch_err_i,
    output logic [core_pkg::XLEN-1:0] instr_o,
    output logic [core_pkg::XLEN-1:0] pc_o,
    output logic                      retire_en_o,
    input  logic                      branch_taken_i,
    input  logic [core_pkg::XLEN-1:0] branch_target_i,
    input  logic                      halt_i,          // ebreak
    input  logic                      illegal_i,
    output logic                      halted_o,
    output logic                      fault_o
);
    import core_pkg::*;

    core_state_e     state_q;
    logic [XLEN-1:0] pc_q;
    logic            wait_q;    // read outstanding on the bus

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state_q     <= CORE_FETCH;
            pc_q        <= RESET_PC;
            wait_q      <= 1'b0;
            fetch_req_o <= 1'b0;
            fault_o     <= 1'b0;
        end else begin
            fetch_req_o <= 1'b0;
            case (state_q)
                CORE_FETCH: begin
                    if (!wait_q) begin              // only right after reset
                        fetch_req_o <= 1'b1;
                        wait_q      <= 1'b1;
                    end else if (fetch_done_i) begin
                        wait_q  <= 1'b0;
                        state_q <= fetch_err_i ? CORE_HALT : CORE_EXEC;
                        fault_o <= fetch_err_i;     // bad resp, no commit
                    end
                end
                CORE_EXEC: begin
                    if (illegal_i || halt_i) begin
                        state_q <= CORE_HALT;
                        fault_o <= illegal_i;
                    end else begin
                        pc_q        <= branch_taken_i ? branch_target_i : pc_q + 32'd4;
                        fetch_req_o <= 1'b1;        // next fetch right behind retire
                        wait_q      <= 1'b1;
                        state_q     <= CORE_FETCH;
                    end
                end
                CORE_HALT: ;                        // parked
                default:   state_q <= CORE_HALT;
            endcase
        end
    end

    // word select by pc bit 2 within the 64-bit beat
    always_ff @(posedge clock) begin
        if (state_q == CORE_FETCH && fetch_done_i) begin
            instr_o <= pc_q[2] ? fetch_data_i[63:32] : fetch_data_i[31:0];
        end
    end

    assign fetch_addr_o = pc_q;
    assign pc_o         = pc_q;
    assign retire_en_o  = (state_q == CORE_EXEC) && !illegal_i;  // illegal never commits
    assign halted_o     = (state_q == CORE_HALT);

    a_no_fetch_halt: assert property (@(posedge clock) disable iff (!reset)
        halted_o |-> !fetch_req_o);

endmodule

// File: hdl/decode.sv
`timescale 1ns/1ns

module decode (
    input  logic [core_pkg::XLEN-1:0] instr_i,
    output logic [4:0]                rs1_o,
    output logic [4:0]                rs2_o,
    output logic [4:0]                rd_o,         // zero when nothing is written
    output logic [core_pkg::XLEN-1:0] imm_o,
    output core_pkg::alu_op_e         alu_op_o,
    output logic                      use_imm_o,
    output logic                      reg_write_o,
    output logic                      is_branch_o,
    output logic                      halt_o,
    output logic                      illegal_o
);
    import core_pkg::*;

    localparam logic [XLEN-1:0] EBREAK_WORD = 32'h0010_0073;

    opcode_e         opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_b;

    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];
    assign rs1_o  = instr_i[19:15];
    assign rs2_o  = instr_i[24:20];
    assign rd_o   = reg_write_o ? instr_i[11:7] : 5'd0;

    // immediates, sign from bit 31
    assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_u = {instr_i[31:12], 12'b0};
    assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7],
                    instr_i[30:25], instr_i[11:8], 1'b0};

    // unknown major opcodes fold into one value
    always_comb begin
        case (instr_i[6:0])
            OP_IMM, OP, LUI, BRANCH, SYSTEM: opcode = opcode_e'(instr_i[6:0]);
            default:                         opcode = OP_ILLEGAL;
        endcase
    end

    always_comb begin
        alu_op_o    = ALU_ADD;
        imm_o       = imm_i;
        use_imm_o   = 1'b0;
        reg_write_o = 1'b0;
        is_branch_o = 1'b0;
        halt_o      = 1'b0;
        illegal_o   = 1'b0;
        case (opcode)
            OP_IMM: begin
                use_imm_o   = 1'b1;
                reg_write_o = 1'b1;
                illegal_o   = (funct3 != 3'b000);   // addi only
            end
            OP: begin
                reg_write_o = 1'b1;
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: alu_op_o = ALU_ADD;
                    {7'b0100000, 3'b000}: alu_op_o = ALU_SUB;
                    {7'b0000000, 3'b100}: alu_op_o = ALU_XOR;
                    default:              illegal_o = 1'b1;
                endcase
            end
            LUI: begin
                alu_op_o    = ALU_PASS_B;
                imm_o       = imm_u;
                use_imm_o   = 1'b1;
                reg_write_o = 1'b1;
            end
            BRANCH: begin
                alu_op_o    = ALU_NE;
                imm_o       = imm_b;
                is_branch_o = 1'b1;
                illegal_o   = (funct3 != 3'b001);   // bne only
            end
            SYSTEM: begin
                halt_o    = (instr_i == EBREAK_WORD);
                illegal_o = (instr_i != EBREAK_WORD);
            end
            default: illegal_o = 1'b1;
        endcase
    end

endmodule

// File: hdl/execute.sv
`timescale 1ns/1ns

module execute (
    input  logic [core_pkg::XLEN-1:0] pc_i,
    input  logic [core_pkg::XLEN-1:0] rs1_data_i,
    input  logic [core_pkg::XLEN-1:0] rs2_data_i,
    input  logic [core_pkg::XLEN-1:0] imm_i,
    input  core_pkg::alu_op_e         alu_op_i,
    input  logic                      use_imm_i,
    input  logic                      is_branch_i,
    output logic [core_pkg::XLEN-1:0] result_o,
    output logic                      branch_taken_o,
    output logic [core_pkg::XLEN-1:0] branch_target_o
);
    import core_pkg::*;

    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic            ne;      // operands differ

    assign op_a = rs1_data_i;
    assign op_b = use_imm_i ? imm_i : rs2_data_i;   // imm for addi and lui
    assign ne   = (op_a != op_b);

    always_comb begin
        case (alu_op_i)
            ALU_ADD:    result_o = op_a + op_b;
            ALU_SUB:    result_o = op_a - op_b;
            ALU_XOR:    result_o = op_a ^ op_b;
            ALU_PASS_B: result_o = op_b;
            ALU_NE:     result_o = {{(XLEN-1){1'b0}}, ne};
            default:    result_o = '0;
        endcase
    end

    // bne, pc-relative target
    assign branch_taken_o  = is_branch_i && ne;
    assign branch_target_o = pc_i + imm_i;

endmodule

// File: hdl/retire.sv
`timescale 1ns/1ns

module retire (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      retire_en_i,
    input  logic [core_pkg::XLEN-1:0] pc_i,
    input  logic [4:0]                rd_i,
    input  logic                      reg_write_i,
    input  logic [core_pkg::XLEN-1:0] result_i,
    input  logic [4:0]                rs1_i,
    input  logic [4:0]                rs2_i,
    output logic [core_pkg::XLEN-1:0] rs1_data_o,
    output logic [core_pkg::XLEN-1:0] rs2_data_o,
    output logic                      commit_valid_o,
    output logic [core_pkg::XLEN-1:0] commit_pc_o,
    output logic [4:0]                commit_rd_o,
    output logic [core_pkg::XLEN-1:0] commit_data_o
);
    import core_pkg::*;

    logic [XLEN-1:0] reg_file [1:31];    // x1..x31, x0 not stored
    logic            wr_en;

    assign wr_en = retire_en_i && reg_write_i && (rd_i != 5'd0);

    always_ff @(posedge clock) begin
        if (wr_en) begin
            reg_file[rd_i] <= result_i;
        end
    end

    // async reads, x0 ties to zero
    assign rs1_data_o = (rs1_i == 5'd0) ? '0 : reg_file[rs1_i];
    assign rs2_data_o = (rs2_i == 5'd0) ? '0 : reg_file[rs2_i];

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            commit_valid_o <= 1'b0;
        end else begin
            commit_valid_o <= retire_en_i;    // one cycle behind retire
        end
    end

    // commit record
    always_ff @(posedge clock) begin
        if (retire_en_i) begin
            commit_pc_o   <= pc_i;
            commit_rd_o   <= rd_i;
            commit_data_o <= wr_en ? result_i : '0;  // branch, ebreak report zero
        end
    end

    a_x0_clean: assert property (@(posedge clock) disable iff (!reset)
        commit_valid_o && (commit_rd_o == 5'd0) |-> commit_data_o == '0);

endmodule

// File: hdl/rv_core_top.sv
`timescale 1ns/1ns

module rv_core_top #(
    parameter logic [core_pkg::XLEN-1:0] RESET_PC       = '0,
    parameter int                        AXI_ADDR_WIDTH = 32
) (
    input  logic                      clock,
    input  logic                      reset,
    // axi read address
    input  logic                      axi_ar_ready_i,
    output logic                      axi_ar_valid_o,
    output logic [AXI_ADDR_WIDTH-1:0] axi_ar_addr_o,
    // axi read data
    output logic                      axi_r_ready_o,
    input  logic                      axi_r_valid_i,
    input  logic [63:0]               axi_r_data_i,
    input  logic [1:0]                axi_r_resp_i,
    // commit port
    output logic                      commit_valid_o,
    output logic [core_pkg::XLEN-1:0] commit_pc_o,
    output logic [4:0]                commit_rd_o,
    output logic [core_pkg::XLEN-1:0] commit_data_o,
    output logic                      halted_o,
    output logic                      fault_o
);
    import core_pkg::*;

    logic                      fetch_req;
    logic [XLEN-1:0]           fetch_addr;
    logic [AXI_ADDR_WIDTH-1:0] fetch_addr_bus;   // pc sized to the bus
    logic                      fetch_done;
    logic [63:0]               fetch_data;
    logic                      fetch_err;
    logic [XLEN-1:0]           instr;
    logic [XLEN-1:0]           pc;
    logic                      retire_en;
    logic                      branch_taken;
    logic [XLEN-1:0]           branch_target;
    logic                      halt;
    logic                      illegal;
    logic [4:0]                rs1;
    logic [4:0]                rs2;
    logic [4:0]                rd;
    logic [XLEN-1:0]           imm;
    alu_op_e                   alu_op;
    logic                      use_imm;
    logic                      reg_write;
    logic                      is_branch;
    logic [XLEN-1:0]           rs1_data;
    logic [XLEN-1:0]           rs2_data;
    logic [XLEN-1:0]           result;

    assign fetch_addr_bus = AXI_ADDR_WIDTH'(fetch_addr);

    axi_rd_master #(.AXI_ADDR_WIDTH(AXI_ADDR_WIDTH)) axi_rd_master_inst (
        .clock(clock), .reset(reset),
        .rw_valid_i(fetch_req), .rw_addr_i(fetch_addr_bus), .rw_ready_o(fetch_done),
        .rw_err_o(fetch_err), .data_read_o(fetch_data),
        .axi_ar_ready_i(axi_ar_ready_i), .axi_ar_valid_o(axi_ar_valid_o),
        .axi_ar_addr_o(axi_ar_addr_o), .axi_r_ready_o(axi_r_ready_o),
        .axi_r_valid_i(axi_r_valid_i), .axi_r_data_i(axi_r_data_i),
        .axi_r_resp_i(axi_r_resp_i)
    );

    fetch_ctrl #(.RESET_PC(RESET_PC)) fetch_ctrl_inst (
        .clock(clock), .reset(reset),
        .fetch_req_o(fetch_req), .fetch_addr_o(fetch_addr), .fetch_done_i(fetch_done),
        .fetch_data_i(fetch_data), .fetch_err_i(fetch_err), .instr_o(instr), .pc_o(pc),
        .retire_en_o(retire_en), .branch_taken_i(branch_taken),
        .branch_target_i(branch_target), .halt_i(halt), .illegal_i(illegal),
        .halted_o(halted_o), .fault_o(fault_o)
    );

    decode decode_inst (
        .instr_i(instr), .rs1_o(rs1), .rs2_o(rs2), .rd_o(rd), .imm_o(imm),
        .alu_op_o(alu_op), .use_imm_o(use_imm), .reg_write_o(reg_write),
        .is_branch_o(is_branch), .halt_o(halt), .illegal_o(illegal)
    );

    execute execute_inst (
        .pc_i(pc), .rs1_data_i(rs1_data), .rs2_data_i(rs2_data), .imm_i(imm),
        .alu_op_i(alu_op), .use_imm_i(use_imm), .is_branch_i(is_branch),
        .result_o(result), .branch_taken_o(branch_taken), .branch_target_o(branch_target)
    );

    retire retire_inst (
        .clock(clock), .reset(reset),
        .retire_en_i(retire_en), .pc_i(pc), .rd_i(rd), .reg_write_i(reg_write),
        .result_i(result), .rs1_i(rs1), .rs2_i(rs2),
        .rs1_data_o(rs1_data), .rs2_data_o(rs2_data),
        .commit_valid_o(commit_valid_o), .commit_pc_o(commit_pc_o),
        .commit_rd_o(commit_rd_o), .commit_data_o(commit_data_o)
    );

endmodule

// File: dv/axi_mem_model.sv
`timescale 1ns/1ns

module axi_mem_model #(
    parameter logic [31:0] ERR_ADDR  = 32'h0000_0f00,  // answered with slverr
    parameter logic [31:0] PROG_BASE = 32'h0000_0080
) (
    input  logic        clock,
    input  logic        reset,
    input  logic        ar_valid_i,
    input  logic [31:0] ar_addr_i,
    output logic        ar_ready_o,
    input  logic        r_ready_i,
    output logic        r_valid_o,
    output logic [63:0] r_data_o,
    output logic [1:0]  r_resp_o
);
    import core_pkg::*;

    logic [31:0] prog [0:63];   // 256-byte window, upper address bits ignored
    logic [15:0] lfsr;
    logic        pend;          // address taken, beat not yet handed over
    logic [31:0] addr_q;
    logic        rst_q;         // reset as seen at the edge
    logic [5:0]  n;

    // galois lfsr, x^16+x^14+x^13+x^11+1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [4:0] rd);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_bne(input logic [12:0] off, input logic [4:0] rs1,
                                            input logic [4:0] rs2);
        return {off[12], off[10:5], rs2, rs1, 3'b001, off[4:1], off[11], 7'b1100011};
    endfunction

    task automatic put(input logic [31:0] word);
        prog[n] = word;
        n = n + 6'd1;
    endtask

    initial begin
        lfsr       = 16'd58488;
        pend       = 1'b0;
        ar_ready_o = 1'b0;
        r_valid_o  = 1'b0;
        r_data_o   = '0;
        r_resp_o   = AXI_RESP_OKAY;
        for (int i = 0; i < 64; i++) begin
            prog[i] = {16'hffff, 8'h00, 6'(i), 2'b00};   // fill tagged with its own address
        end
        n = PROG_BASE[7:2];
        put(enc_i(12'd4, 5'd0, 5'd1));                    // x1 loop count
        put(enc_i(12'd0, 5'd0, 5'd2));
        put({20'h12345, 5'd3, 7'b0110111});               // lui x3
        put(enc_i(12'h678, 5'd3, 5'd3));
        put(enc_i(12'hfff, 5'd0, 5'd4));                  // x4 = -1
        put(enc_r(7'h00, 5'd4, 5'd3, 3'b100, 5'd5));      // xor, x5 = ~x3
        put(enc_r(7'h00, 5'd3, 5'd2, 3'b000, 5'd2));      // loop top
        put(enc_r(7'h00, 5'd5, 5'd2, 3'b100, 5'd6));
        put(enc_i(12'hfff, 5'd1, 5'd1));                  // count down
        put(enc_bne(-13'd12, 5'd1, 5'd0));                // back 3 times
        put(enc_r(7'h20, 5'd2, 5'd5, 3'b000, 5'd7));      // sub
        put(enc_bne(13'd8, 5'd7, 5'd7));                  // equal regs, falls through
        put(enc_i(12'd5, 5'd0, 5'd0));                    // x0 write dropped
        put(enc_i(12'h7ff, 5'd7, 5'd8));
        put(enc_bne(13'd8, 5'd8, 5'd0));                  // forward skip
        put(enc_i(12'd1, 5'd0, 5'd9));                    // never runs
        put({20'hfffff, 5'd10, 7'b0110111});
        put(enc_r(7'h20, 5'd10, 5'd0, 3'b000, 5'd11));
        put(enc_r(7'h00, 5'd4, 5'd11, 3'b100, 5'd12));
        put(enc_r(7'h00, 5'd8, 5'd12, 3'b000, 5'd13));
        put(32'h0010_0073);                               // ebreak
    end

    // sample at the edge, drive 1 ns later
    always @(posedge clock) begin
        logic ar_hs;
        logic r_hs;
        ar_hs = ar_valid_i && ar_ready_o;
        r_hs  = r_valid_o && r_ready_i;
        rst_q = reset;
        if (ar_hs) begin
            pend   = 1'b1;
            addr_q = ar_addr_i;
        end
        #1;
        if (!rst_q) begin
            pend       = 1'b0;
            ar_ready_o = 1'b0;
            r_valid_o  = 1'b0;
        end else begin
            if (r_hs) begin
                r_valid_o = 1'b0;
                pend      = 1'b0;
            end else if (pend && !r_valid_o) begin
                r_valid_o = lfsr[0];                      // random data stall
                lfsr      = lfsr_step(lfsr);
                r_resp_o  = (addr_q == ERR_ADDR) ? 2'b10 : AXI_RESP_OKAY;
                r_data_o  = (addr_q == ERR_ADDR) ? 64'd0 :
                            {prog[{addr_q[7:3], 1'b1}], prog[{addr_q[7:3], 1'b0}]};
            end
            if (!pend) begin
                ar_ready_o = lfsr[0];                     // random address stall
                lfsr       = lfsr_step(lfsr);
            end else begin
                ar_ready_o = 1'b0;                        // one read outstanding
            end
        end
    end

endmodule

// File: dv/tb_top.sv
`timescale 1ns/1ns

module tb_top;
    import core_pkg::*;

    localparam logic [31:0] RESET_PC         = 32'h0000_0080;
    localparam logic [31:0] ERR_ADDR         = 32'h0000_0f00;
    localparam int          EXPECTED_COMMITS = 32;   // 6 setup, 4 loop passes of 4, 10 tail
    localparam int          EXPECTED_TAKEN   = 4;    // 3 loop back, 1 forward skip
    // commits plus fault run and slack, 75 cycles of stall budget each
    localparam int          TIMEOUT_CYCLES   = (EXPECTED_COMMITS + 8) * 75;

    logic        clock;
    logic        reset;
    logic        err_reset;                         // fault core, parked until the first halts
    logic        ar_ready, ar_valid, r_ready, r_valid;
    logic [31:0] ar_addr;
    logic [63:0] r_data;
    logic [1:0]  r_resp;
    logic        commit_valid, halted, fault;
    logic [31:0] commit_pc, commit_data;
    logic [4:0]  commit_rd;
    logic        e_ar_ready, e_ar_valid, e_r_ready, e_r_valid;
    logic [31:0] e_ar_addr;
    logic [63:0] e_r_data;
    logic [1:0]  e_r_resp;
    logic        e_commit_valid, e_halted, e_fault;
    logic [31:0] e_commit_pc, e_commit_data;
    logic [4:0]  e_commit_rd;
    logic [31:0] shadow [0:31];                     // reference register file
    logic [31:0] next_pc = RESET_PC;                // expected next fetch address
    logic        r_window = 1'b0;                   // between ar and r handshakes
    logic        fetch_seen = 1'b0;
    logic        ebreak_seen = 1'b0;
    int          commits = 0;
    int          taken = 0;
    int          errors = 0;
    int          cycles = 0;

    rv_core_top #(.RESET_PC(RESET_PC), .AXI_ADDR_WIDTH(32)) rv_core_top_inst (
        .clock(clock), .reset(reset), .axi_ar_ready_i(ar_ready), .axi_ar_valid_o(ar_valid),
        .axi_ar_addr_o(ar_addr), .axi_r_ready_o(r_ready), .axi_r_valid_i(r_valid),
        .axi_r_data_i(r_data), .axi_r_resp_i(r_resp), .commit_valid_o(commit_valid),
        .commit_pc_o(commit_pc), .commit_rd_o(commit_rd), .commit_data_o(commit_data),
        .halted_o(halted), .fault_o(fault)
    );

    axi_mem_model #(.ERR_ADDR(ERR_ADDR), .PROG_BASE(RESET_PC)) axi_mem_model (
        .clock(clock), .reset(reset), .ar_valid_i(ar_valid), .ar_addr_i(ar_addr),
        .ar_ready_o(ar_ready), .r_ready_i(r_ready), .r_valid_o(r_valid),
        .r_data_o(r_data), .r_resp_o(r_resp)
    );

    // second core boots straight into the error address
    rv_core_top #(.RESET_PC(ERR_ADDR), .AXI_ADDR_WIDTH(32)) fault_core_inst (
        .clock(clock), .reset(err_reset), .axi_ar_ready_i(e_ar_ready),
        .axi_ar_valid_o(e_ar_valid), .axi_ar_addr_o(e_ar_addr), .axi_r_ready_o(e_r_ready),
        .axi_r_valid_i(e_r_valid), .axi_r_data_i(e_r_data), .axi_r_resp_i(e_r_resp),
        .commit_valid_o(e_commit_valid), .commit_pc_o(e_commit_pc),
        .commit_rd_o(e_commit_rd), .commit_data_o(e_commit_data),
        .halted_o(e_halted), .fault_o(e_fault)
    );

    axi_mem_model #(.ERR_ADDR(ERR_ADDR), .PROG_BASE(RESET_PC)) fault_mem_model (
        .clock(clock), .reset(err_reset), .ar_valid_i(e_ar_valid), .ar_addr_i(e_ar_addr),
        .ar_ready_o(e_ar_ready), .r_ready_i(e_r_ready), .r_valid_o(e_r_valid),
        .r_data_o(e_r_data), .r_resp_o(e_r_resp)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    // address phase held under slave stalls
    ar_hold: assert property (@(posedge clock) disable iff (!reset)
        ar_valid && !ar_ready |=> ar_valid && $stable(ar_addr))
        else begin
            errors++;
            $display("ar_valid dropped or the address moved before ar_ready");
        end

    always @(posedge clock) begin
        logic [31:0] word;
        logic [31:0] exp_data;
        logic [4:0]  exp_rd;
        logic        brt;
        if (!reset) begin
            assert (!ar_valid && !commit_valid && !halted && !fault) else begin
                errors++;
                $display("core outputs active while reset is asserted");
            end
        end else begin
            if (ar_valid && ar_ready) begin
                assert (ar_addr == next_pc) else begin
                    errors++;
                    $display("[FAIL] axi_ar_addr_o: got %h, expected %h", ar_addr, next_pc);
                end
                fetch_seen = 1'b1;
            end
            assert (r_ready == r_window) else begin
                errors++;
                $display("[FAIL] axi_r_ready_o: got %h, expected %h", r_ready, r_window);
            end
            if (ar_valid && ar_ready) r_window = 1'b1;
            if (r_valid && r_ready) r_window = 1'b0;
            assert (fetch_seen || !commit_valid) else begin
                errors++;
                $display("commit seen before the first fetch");
            end
            if (commit_valid) begin
                // program order, so the commit pc is the last fetch target
                assert (commit_pc == next_pc) else begin
                    errors++;
                    $display("[FAIL] commit_pc_o: got %h, expected %h", commit_pc, next_pc);
                end
                word     = axi_mem_model.prog[commit_pc[7:2]];   // program as stored
                exp_rd   = word[11:7];
                exp_data = 32'd0;
                brt      = 1'b0;
                case (opcode_e'(word[6:0]))
                    OP_IMM: exp_data = shadow[word[19:15]] + {{20{word[31]}}, word[31:20]};
                    OP: begin
                        if (word[30])                        // sub
                            exp_data = shadow[word[19:15]] - shadow[word[24:20]];
                        else if (word[14:12] == 3'b100)      // xor
                            exp_data = shadow[word[19:15]] ^ shadow[word[24:20]];
                        else
                            exp_data = shadow[word[19:15]] + shadow[word[24:20]];
                    end
                    LUI: exp_data = {word[31:12], 12'h000};
                    BRANCH: begin
                        exp_rd = 5'd0;
                        brt    = (shadow[word[19:15]] != shadow[word[24:20]]);
                    end
                    default: begin
                        exp_rd      = 5'd0;
                        ebreak_seen = (word == 32'h0010_0073);
                    end
                endcase
                if (exp_rd == 5'd0) exp_data = 32'd0;        // x0 keeps zero
                assert (commit_rd == exp_rd) else begin
                    errors++;
                    $display("[FAIL] commit_rd_o: got %h, expected %h", commit_rd, exp_rd);
                end
                assert (commit_data == exp_data) else begin
                    errors++;
                    $display("[FAIL] commit_data_o: got %h, expected %h", commit_data, exp_data);
                end
                shadow[exp_rd] = exp_data;
                commits++;
                if (brt) taken++;
                next_pc = brt ? commit_pc + {{19{word[31]}}, word[31], word[7], word[30:25],
                                             word[11:8], 1'b0}
                              : commit_pc + 32'd4;
            end
            if (halted) begin
                assert (ebreak_seen && !fault && !ar_valid) else begin
                    errors++;
                    $display("halt without ebreak, or with fault or a fetch after it");
                end
            end
        end
    end

    // fault core never commits
    always @(posedge clock) begin
        if (err_reset) begin
            assert (!e_commit_valid) else begin
                errors++;
                $display("fault run committed an instruction");
            end
        end
    end

    always @(posedge clock) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, a core never reached its halt", cycles);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    initial begin
        reset     = 1'b0;
        err_reset = 1'b0;
        for (int i = 0; i < 32; i++) begin
            shadow[i] = 32'd0;
        end
        repeat (2) @(posedge clock);
        #1 reset = 1'b1;
        while (!halted) @(posedge clock);
        repeat (20) @(posedge clock);                        // quiet window after halt
        assert (commits == EXPECTED_COMMITS) else begin
            errors++;
            $display("[FAIL] commit count: got %h, expected %h", commits, EXPECTED_COMMITS);
        end
        assert (taken == EXPECTED_TAKEN) else begin
            errors++;
            $display("[FAIL] taken branches: got %h, expected %h", taken, EXPECTED_TAKEN);
        end
        @(posedge clock);
        #1 err_reset = 1'b1;                                 // fault run
        while (!e_halted) @(posedge clock);
        repeat (2) @(posedge clock);
        assert (e_fault && e_halted) else begin
            errors++;
            $display("[FAIL] fault_o: got %h, expected %h", e_fault, 1'b1);
        end
        $display("%0d commits, %0d taken branches, %0d errors", commits, taken, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: sources.f
hdl/core_pkg.sv
hdl/axi_rd_master.sv
hdl/fetch_ctrl.sv
hdl/decode.sv
hdl/execute.sv
hdl/retire.sv
hdl/rv_core_top.sv
dv/axi_mem_model.sv
dv/tb_top.sv

// File: run.sh
#!/bin/sh
# build the core testbench with verilator, run it, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_top -f sources.f -o tb_top_sim \
    && ./obj_dir/tb_top_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "TEST RESULT: PASS" sim.log 2>/dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }
